// File: design/dist_pkg.sv
`default_nettype none

package dist_pkg;

	//////////////////////////////////////////////////////////////////////
	// stream fan-out
	//////////////////////////////////////////////////////////////////////

	// leaves at the bottom of the two-level tree
	localparam int NUM_LEAVES = 4;

	// switch command, one bit per output branch
	// 00 none, 01 low, 10 high, 11 duplicate
	typedef logic [1:0] dist_cmd_t;
	localparam int CMD_LOW_BIT  = 0;
	localparam int CMD_HIGH_BIT = 1;

	// cfg word as it sits in REG_CFG, en in bit 0
	typedef struct packed {
		dist_cmd_t cmd_high;
		dist_cmd_t cmd_low;
		dist_cmd_t cmd_root;
		logic      en;
	} dist_cfg_t;

	//////////////////////////////////////////////////////////////////////
	// wishbone register map
	//////////////////////////////////////////////////////////////////////

	localparam int WB_ADDR_WIDTH = 3;
	localparam int WB_DATA_WIDTH = 32;
	localparam int CNT_WIDTH     = 32;

	typedef logic [WB_ADDR_WIDTH-1:0] wb_addr_t;
	typedef logic [WB_DATA_WIDTH-1:0] wb_data_t;
	typedef logic [CNT_WIDTH-1:0]     leaf_cnt_t;

	// word addresses
	localparam wb_addr_t REG_CFG  = 3'd0;
	localparam wb_addr_t REG_CNT0 = 3'd1;
	localparam wb_addr_t REG_CNT1 = 3'd2;
	localparam wb_addr_t REG_CNT2 = 3'd3;
	localparam wb_addr_t REG_CNT3 = 3'd4;

endpackage

`default_nettype wire

// File: design/mux_2x1_comb.sv
`timescale 1ns/1ps
`default_nettype none

module mux_2x1_comb #(
	parameter int DATA_WIDTH = 32
) (
	// two candidate words, upper one selected by i_sel = 1
	input  wire  [1:0]              i_valid,
	input  wire  [2*DATA_WIDTH-1:0] i_data_bus,

	// control
	input  wire                     i_en,
	input  wire                     i_sel,

	// chosen word
	output logic                    o_valid,
	output logic [DATA_WIDTH-1:0]   o_data_bus
);

	logic                  sel_valid;
	logic [DATA_WIDTH-1:0] sel_data;

	// pick one side of the bus
	always_comb
	begin
		sel_valid = i_valid[i_sel];
		if (i_sel)
			sel_data = i_data_bus[DATA_WIDTH +: DATA_WIDTH];
		else
			sel_data = i_data_bus[0 +: DATA_WIDTH];
	end

	// disabled or empty side gives a zero word, valid low
	// keeps invalid beats from leaking data downstream
	always_comb
	begin
		if (i_en && sel_valid)
		begin
			o_valid    = 1'b1;
			o_data_bus = sel_data;
		end
		else
		begin
			o_valid    = 1'b0;
			o_data_bus = '0;
		end
	end

endmodule

`default_nettype wire

// File: design/distribute_1x2_comb.sv
`timescale 1ns/1ps
`default_nettype none

module distribute_1x2_comb #(
	parameter int DATA_WIDTH = 32
) (
	// incoming beat
	input  wire                      i_valid,
	input  wire  [DATA_WIDTH-1:0]    i_data_bus,

	// control
	input  wire                      i_en,
	input  wire  dist_pkg::dist_cmd_t i_cmd,

	// {high, low} branches
	output logic [1:0]               o_valid,
	output logic [2*DATA_WIDTH-1:0]  o_data_bus
);

	import dist_pkg::*;

	// selector valids before the command qualifier
	logic [1:0] mux_valid;

	//////////////////////////////////////////////////////////////////////
	// one selector per branch
	//////////////////////////////////////////////////////////////////////

	// input word on the upper side, dummy zero word on the lower side
	// command bit set picks the real beat
	mux_2x1_comb #(
		.DATA_WIDTH (DATA_WIDTH)
	) u_low_mux (
		.i_valid    ({i_valid, 1'b0}),
		.i_data_bus ({i_data_bus, {DATA_WIDTH{1'b0}}}),
		.i_en       (i_en),
		.i_sel      (i_cmd[CMD_LOW_BIT]),
		.o_valid    (mux_valid[0]),
		.o_data_bus (o_data_bus[0 +: DATA_WIDTH])
	);

	// same structure for the high branch
	mux_2x1_comb #(
		.DATA_WIDTH (DATA_WIDTH)
	) u_high_mux (
		.i_valid    ({i_valid, 1'b0}),
		.i_data_bus ({i_data_bus, {DATA_WIDTH{1'b0}}}),
		.i_en       (i_en),
		.i_sel      (i_cmd[CMD_HIGH_BIT]),
		.o_valid    (mux_valid[1]),
		.o_data_bus (o_data_bus[DATA_WIDTH +: DATA_WIDTH])
	);

	// branch valid needs its command bit
	// none/low/high/duplicate fall out of the two bits
	assign o_valid[0] = i_cmd[CMD_LOW_BIT] & mux_valid[0];
	assign o_valid[1] = i_cmd[CMD_HIGH_BIT] & mux_valid[1];

endmodule

`default_nettype wire

// File: design/dist_tree.sv
`timescale 1ns/1ps
`default_nettype none

module dist_tree #(
	parameter int DATA_WIDTH = 32
) (
	input  wire                                     i_clk,
	input  wire                                     i_arst_n,

	// routing config from the register slave
	input  wire  dist_pkg::dist_cfg_t               i_cfg,

	// input stream, valid only
	input  wire                                     i_valid,
	input  wire  [DATA_WIDTH-1:0]                   i_data,

	// leaf 0 in the low slice
	output logic [dist_pkg::NUM_LEAVES-1:0]         o_leaf_valid,
	output logic [dist_pkg::NUM_LEAVES*DATA_WIDTH-1:0] o_leaf_data
);

	import dist_pkg::*;

	// root switch, combinational
	logic [1:0]              root_valid;
	logic [2*DATA_WIDTH-1:0] root_data;

	// level 1 registers, {high, low}
	logic [1:0]              lvl1_valid_q;
	logic [2*DATA_WIDTH-1:0] lvl1_data_q;

	// second level switches, combinational
	logic [1:0]              sw_low_valid;
	logic [2*DATA_WIDTH-1:0] sw_low_data;
	logic [1:0]              sw_high_valid;
	logic [2*DATA_WIDTH-1:0] sw_high_data;

	// level 2, the leaf registers
	logic [NUM_LEAVES-1:0]            leaf_valid_q;
	logic [NUM_LEAVES*DATA_WIDTH-1:0] leaf_data_q;

	//////////////////////////////////////////////////////////////////////
	// level 1: root split
	//////////////////////////////////////////////////////////////////////

	// en gates only here, beats already inside still drain
	distribute_1x2_comb #(
		.DATA_WIDTH (DATA_WIDTH)
	) u_root (
		.i_valid    (i_valid),
		.i_data_bus (i_data),
		.i_en       (i_cfg.en),
		.i_cmd      (i_cfg.cmd_root),
		.o_valid    (root_valid),
		.o_data_bus (root_data)
	);

	// captured every edge, no hold
	always_ff @(posedge i_clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			lvl1_valid_q <= '0;
			lvl1_data_q  <= '0;
		end
		else
		begin
			lvl1_valid_q <= root_valid;
			lvl1_data_q  <= root_data;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// level 2: leaf split
	//////////////////////////////////////////////////////////////////////

	// low branch serves leaves 0 and 1
	distribute_1x2_comb #(
		.DATA_WIDTH (DATA_WIDTH)
	) u_sw_low (
		.i_valid    (lvl1_valid_q[0]),
		.i_data_bus (lvl1_data_q[0 +: DATA_WIDTH]),
		.i_en       (1'b1),
		.i_cmd      (i_cfg.cmd_low),
		.o_valid    (sw_low_valid),
		.o_data_bus (sw_low_data)
	);

	// high branch serves leaves 2 and 3
	distribute_1x2_comb #(
		.DATA_WIDTH (DATA_WIDTH)
	) u_sw_high (
		.i_valid    (lvl1_valid_q[1]),
		.i_data_bus (lvl1_data_q[DATA_WIDTH +: DATA_WIDTH]),
		.i_en       (1'b1),
		.i_cmd      (i_cfg.cmd_high),
		.o_valid    (sw_high_valid),
		.o_data_bus (sw_high_data)
	);

	// leaf order 3..0 = high.high, high.low, low.high, low.low
	always_ff @(posedge i_clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			leaf_valid_q <= '0;
			leaf_data_q  <= '0;
		end
		else
		begin
			leaf_valid_q <= {sw_high_valid, sw_low_valid};
			leaf_data_q  <= {sw_high_data, sw_low_data};
		end
	end

	assign o_leaf_valid = leaf_valid_q;
	assign o_leaf_data  = leaf_data_q;

endmodule

`default_nettype wire

// File: design/dist_cfg_wb.sv
`timescale 1ns/1ps
`default_nettype none

module dist_cfg_wb (
	input  wire                             i_clk,
	input  wire                             i_arst_n,

	// wishbone classic slave
	input  wire                             i_wb_cyc,
	input  wire                             i_wb_stb,
	input  wire                             i_wb_we,
	input  wire  dist_pkg::wb_addr_t        i_wb_adr,
	input  wire  dist_pkg::wb_data_t        i_wb_dat,
	output dist_pkg::wb_data_t              o_wb_dat,
	output logic                            o_wb_ack,

	// leaf valids back from the tree
	input  wire  [dist_pkg::NUM_LEAVES-1:0] i_leaf_valid,

	// routing config to the tree
	output dist_pkg::dist_cfg_t             o_cfg
);

	import dist_pkg::*;

	logic      ack_q;
	wb_data_t  rd_data_q;
	wb_data_t  rd_mux;
	dist_cfg_t cfg_q;
	leaf_cnt_t cnt_q [NUM_LEAVES];

	logic      req;
	logic      wr_en;

	//////////////////////////////////////////////////////////////////////
	// bus handshake
	//////////////////////////////////////////////////////////////////////

	// first cycle of a request, ack not yet given
	assign req   = i_wb_cyc & i_wb_stb & ~ack_q;
	// master still holds the write during ack
	assign wr_en = i_wb_cyc & i_wb_stb & i_wb_we & ack_q;

	// read mux, unmapped addresses give zero
	always_comb
	begin
		case (i_wb_adr)
			REG_CFG:  rd_mux = {{(WB_DATA_WIDTH-$bits(dist_cfg_t)){1'b0}}, cfg_q};
			REG_CNT0: rd_mux = cnt_q[0];
			REG_CNT1: rd_mux = cnt_q[1];
			REG_CNT2: rd_mux = cnt_q[2];
			REG_CNT3: rd_mux = cnt_q[3];
			default:  rd_mux = '0;
		endcase
	end

	// one-cycle ack, read data lands with it
	always_ff @(posedge i_clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			ack_q     <= 1'b0;
			rd_data_q <= '0;
		end
		else
		begin
			ack_q <= req;
			if (req && !i_wb_we)
				rd_data_q <= rd_mux;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// config and delivery counters
	//////////////////////////////////////////////////////////////////////

	// only REG_CFG is writable, low 7 bits kept
	always_ff @(posedge i_clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
			cfg_q <= '0;
		else if (wr_en && i_wb_adr == REG_CFG)
			cfg_q <= dist_cfg_t'(i_wb_dat[$bits(dist_cfg_t)-1:0]);
	end

	// one count per valid leaf cycle, wraps
	always_ff @(posedge i_clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			for (int k = 0; k < NUM_LEAVES; k++)
				cnt_q[k] <= '0;
		end
		else
		begin
			for (int k = 0; k < NUM_LEAVES; k++)
				cnt_q[k] <= cnt_q[k] + leaf_cnt_t'(i_leaf_valid[k]);
		end
	end

	assign o_wb_ack = ack_q;
	assign o_wb_dat = rd_data_q;
	assign o_cfg    = cfg_q;

endmodule

`default_nettype wire

// File: design/dist_tree_top.sv
`timescale 1ns/1ps
`default_nettype none

module dist_tree_top #(
	parameter int DATA_WIDTH = 32
) (
	input  wire                                        i_clk,
	input  wire                                        i_arst_n,

	// wishbone classic, config and counters
	input  wire                                        i_wb_cyc,
	input  wire                                        i_wb_stb,
	input  wire                                        i_wb_we,
	input  wire  dist_pkg::wb_addr_t                   i_wb_adr,
	input  wire  dist_pkg::wb_data_t                   i_wb_dat,
	output dist_pkg::wb_data_t                         o_wb_dat,
	output logic                                       o_wb_ack,

	// input stream
	input  wire                                        i_valid,
	input  wire  [DATA_WIDTH-1:0]                      i_data,

	// leaves, two cycles behind the input
	output logic [dist_pkg::NUM_LEAVES-1:0]            o_leaf_valid,
	output logic [dist_pkg::NUM_LEAVES*DATA_WIDTH-1:0] o_leaf_data
);

	import dist_pkg::*;

	// live routing config
	dist_cfg_t cfg;

	// register slave, also counts leaf beats
	dist_cfg_wb u_cfg (
		.i_clk        (i_clk),
		.i_arst_n     (i_arst_n),
		.i_wb_cyc     (i_wb_cyc),
		.i_wb_stb     (i_wb_stb),
		.i_wb_we      (i_wb_we),
		.i_wb_adr     (i_wb_adr),
		.i_wb_dat     (i_wb_dat),
		.o_wb_dat     (o_wb_dat),
		.o_wb_ack     (o_wb_ack),
		.i_leaf_valid (o_leaf_valid),
		.o_cfg        (cfg)
	);

	// two-level distribution tree
	dist_tree #(
		.DATA_WIDTH (DATA_WIDTH)
	) u_tree (
		.i_clk        (i_clk),
		.i_arst_n     (i_arst_n),
		.i_cfg        (cfg),
		.i_valid      (i_valid),
		.i_data       (i_data),
		.o_leaf_valid (o_leaf_valid),
		.o_leaf_data  (o_leaf_data)
	);

endmodule

`default_nettype wire

// File: bench/tb_dist_tree.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dist_tree;

	import dist_pkg::*;

	localparam int DATA_WIDTH  = 32;
	localparam int ACK_TIMEOUT = 16;
	localparam int MAX_RECORDS = 1000;
	localparam int ROUNDS      = 6;
	localparam int STREAM_LEN  = 8;
	localparam int CMD_MIXES   = 64;

	typedef logic [8*24-1:0] name_t;
	typedef logic [127:0]    cmp_t;

	// dut side
	logic                             i_clk = 1'b0;
	logic                             i_arst_n;
	logic                             i_wb_cyc;
	logic                             i_wb_stb;
	logic                             i_wb_we;
	wb_addr_t                         i_wb_adr;
	wb_data_t                         i_wb_dat;
	wb_data_t                         o_wb_dat;
	logic                             o_wb_ack;
	logic                             i_valid;
	logic [DATA_WIDTH-1:0]            i_data;
	logic [NUM_LEAVES-1:0]            o_leaf_valid;
	logic [NUM_LEAVES*DATA_WIDTH-1:0] o_leaf_data;

	// reference state mirrors the register map
	logic [6:0]  cfg_model;
	logic [31:0] cnt_model [NUM_LEAVES];
	logic [31:0] lcg_state = 32'h48da;

	dist_tree_top #(
		.DATA_WIDTH (DATA_WIDTH)
	) u_dist_tree_top (
		.i_clk        (i_clk),
		.i_arst_n     (i_arst_n),
		.i_wb_cyc     (i_wb_cyc),
		.i_wb_stb     (i_wb_stb),
		.i_wb_we      (i_wb_we),
		.i_wb_adr     (i_wb_adr),
		.i_wb_dat     (i_wb_dat),
		.o_wb_dat     (o_wb_dat),
		.o_wb_ack     (o_wb_ack),
		.i_valid      (i_valid),
		.i_data       (i_data),
		.o_leaf_valid (o_leaf_valid),
		.o_leaf_data  (o_leaf_data)
	);

	// 20 ns period
	always #10 i_clk = ~i_clk;

	//////////////////////////////////////////////////////////////////////
	// reference model
	//////////////////////////////////////////////////////////////////////

	// plain lcg with numerical recipes constants
	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// leaf k valid = en & root bit of its half & second level bit
	function automatic logic [3:0] route(input logic [6:0] cfg);
		logic       en;
		logic [1:0] root;
		logic [1:0] low;
		logic [1:0] high;
		en   = cfg[0];
		root = cfg[2:1];
		low  = cfg[4:3];
		high = cfg[6:5];
		return {en & root[1] & high[1], en & root[1] & high[0],
			en & root[0] & low[1], en & root[0] & low[0]};
	endfunction

	// word copied to every valid leaf and zero elsewhere
	function automatic cmp_t leaf_words(input logic [3:0] mv, input logic [31:0] word);
		cmp_t r;
		r = '0;
		for (int k = 0; k < NUM_LEAVES; k++)
			if (mv[k])
				r[k*DATA_WIDTH +: DATA_WIDTH] = word;
		return r;
	endfunction

	function automatic logic [31:0] model_reg(input wb_addr_t addr);
		case (addr)
			REG_CFG:  return {25'b0, cfg_model};
			REG_CNT0: return cnt_model[0];
			REG_CNT1: return cnt_model[1];
			REG_CNT2: return cnt_model[2];
			REG_CNT3: return cnt_model[3];
			default:  return '0;
		endcase
	endfunction

	task automatic add_counts(input logic [3:0] mv);
		for (int k = 0; k < NUM_LEAVES; k++)
			cnt_model[k] = cnt_model[k] + 32'(mv[k]);
	endtask

	//////////////////////////////////////////////////////////////////////
	// checks and bus access
	//////////////////////////////////////////////////////////////////////

	task automatic check_eq(input name_t tname, input string what, input cmp_t exp,
		input cmp_t act);
		assert (act === exp)
		else
		begin
			$display("error %0s %0s expected %h actual %h", tname, what, exp, act);
			$display("Simulation failed");
			$fatal(1);
		end
	endtask

	// ack sampled 1 ns after each edge
	task automatic wait_ack(input name_t tname);
		int waited;
		waited = 0;
		@(posedge i_clk);
		#1;
		while (!o_wb_ack)
		begin
			waited++;
			if (waited >= ACK_TIMEOUT)
			begin
				$display("wishbone ack never came for access %0s", tname);
				$display("Simulation failed");
				$fatal(1);
			end
			@(posedge i_clk);
			#1;
		end
		// ack due in the first cycle after the request
		check_eq(tname, "ack latency", '0, cmp_t'(waited));
	endtask

	// master holds through the ack cycle so the write lands on that edge
	task automatic wb_write(input name_t tname, input wb_addr_t addr, input wb_data_t data);
		i_wb_cyc = 1'b1;
		i_wb_stb = 1'b1;
		i_wb_we  = 1'b1;
		i_wb_adr = addr;
		i_wb_dat = data;
		wait_ack(tname);
		@(posedge i_clk);
		#1;
		i_wb_cyc = 1'b0;
		i_wb_stb = 1'b0;
		i_wb_we  = 1'b0;
		i_wb_adr = '0;
		i_wb_dat = '0;
		// ack lasts one cycle only
		check_eq(tname, "ack after write", '0, cmp_t'(o_wb_ack));
		if (addr == REG_CFG)
			cfg_model = data[6:0];
	endtask

	task automatic wb_read(input name_t tname, input wb_addr_t addr, output wb_data_t data);
		i_wb_cyc = 1'b1;
		i_wb_stb = 1'b1;
		i_wb_we  = 1'b0;
		i_wb_adr = addr;
		wait_ack(tname);
		data = o_wb_dat;
		@(posedge i_clk);
		#1;
		i_wb_cyc = 1'b0;
		i_wb_stb = 1'b0;
		i_wb_adr = '0;
		check_eq(tname, "ack after read", '0, cmp_t'(o_wb_ack));
	endtask

	// compare against the given value and the model
	task automatic read_check(input name_t tname, input wb_addr_t addr, input wb_data_t exp);
		wb_data_t rd;
		wb_read(tname, addr, rd);
		check_eq(tname, "file register", cmp_t'(exp), cmp_t'(rd));
		check_eq(tname, "model register", cmp_t'(model_reg(addr)), cmp_t'(rd));
	endtask

	//////////////////////////////////////////////////////////////////////
	// stream stimulus
	//////////////////////////////////////////////////////////////////////

	// one beat checked two edges later plus one idle cycle for the counters
	task automatic send_beat(input name_t tname, input logic [31:0] word,
		input logic [3:0] fv, input cmp_t fd);
		logic [3:0] mv;
		mv      = route(cfg_model);
		i_valid = 1'b1;
		i_data  = word;
		@(posedge i_clk);
		#1;
		i_valid = 1'b0;
		i_data  = '0;
		@(posedge i_clk);
		#1;
		check_eq(tname, "file leaf valid", cmp_t'(fv), cmp_t'(o_leaf_valid));
		check_eq(tname, "file leaf data", fd, cmp_t'(o_leaf_data));
		check_eq(tname, "rule leaf valid", cmp_t'(mv), cmp_t'(o_leaf_valid));
		check_eq(tname, "rule leaf data", leaf_words(mv, word), cmp_t'(o_leaf_data));
		add_counts(mv);
		@(posedge i_clk);
		#1;
	endtask

	// back to back beats with expectations queued two cycles deep
	task automatic send_stream(input name_t tname, input int count);
		logic [3:0]  pv [$];
		cmp_t        pd [$];
		logic [3:0]  mv;
		logic [31:0] word;
		logic [3:0]  ev;
		cmp_t        ed;
		for (int c = 0; c < count + 2; c++)
		begin
			if (c >= 2)
			begin
				ev = pv.pop_front();
				ed = pd.pop_front();
				check_eq(tname, "stream leaf valid", cmp_t'(ev), cmp_t'(o_leaf_valid));
				check_eq(tname, "stream leaf data", ed, cmp_t'(o_leaf_data));
			end
			if (c < count)
			begin
				word    = next_rand();
				mv      = route(cfg_model);
				i_valid = 1'b1;
			end
			else
			begin
				word    = '0;
				mv      = '0;
				i_valid = 1'b0;
			end
			i_data = word;
			pv.push_back(mv);
			pd.push_back(leaf_words(mv, word));
			add_counts(mv);
			@(posedge i_clk);
			#1;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////////////////////////

	initial
	begin
		logic [7:0]     kind;
		name_t          tname;
		logic [8*120-1:0] line_buf;
		wb_addr_t       addr;
		wb_data_t       data;
		wb_data_t       rd;
		logic [31:0]    word;
		logic [3:0]     fv;
		logic [31:0]    d0;
		logic [31:0]    d1;
		logic [31:0]    d2;
		logic [31:0]    d3;
		logic [31:0]    cfg_w;
		int             fd;
		int             code;
		int             records;
		logic           done;

		i_arst_n  = 1'b0;
		i_wb_cyc  = 1'b0;
		i_wb_stb  = 1'b0;
		i_wb_we   = 1'b0;
		i_wb_adr  = '0;
		i_wb_dat  = '0;
		i_valid   = 1'b0;
		i_data    = '0;
		cfg_model = '0;
		for (int k = 0; k < NUM_LEAVES; k++)
			cnt_model[k] = '0;

		repeat (4) @(posedge i_clk);
		#1;
		i_arst_n = 1'b1;

		check_eq(name_t'("reset_leaves"), "leaf valid", '0, cmp_t'(o_leaf_valid));
		check_eq(name_t'("reset_leaves"), "leaf data", '0, cmp_t'(o_leaf_data));

		// directed records
		fd = $fopen("bench/dist_testdata.txt", "r");
		if (fd == 0)
		begin
			$display("cannot open bench/dist_testdata.txt");
			$display("Simulation failed");
			$fatal(1);
		end
		done    = 1'b0;
		records = 0;
		while (!done && records < MAX_RECORDS)
		begin
			code = $fscanf(fd, " %s", kind);
			if (code != 1)
				done = 1'b1;
			else if (kind == "#")
				code = $fgets(line_buf, fd);
			else
			begin
				records++;
				if (kind == "W")
				begin
					code = $fscanf(fd, " %s %h %h", tname, addr, data);
					if (code == 3)
						wb_write(tname, addr, data);
				end
				else if (kind == "R")
				begin
					code = $fscanf(fd, " %s %h %h", tname, addr, data);
					if (code == 3)
						read_check(tname, addr, data);
				end
				else if (kind == "B")
				begin
					code = $fscanf(fd, " %s %h %h %h %h %h %h", tname, word, fv,
						d0, d1, d2, d3);
					if (code == 7)
					begin
						send_beat(tname, word, fv, {d3, d2, d1, d0});
						code = 3;
					end
				end
				if (code != 3)
				begin
					$display("malformed or unknown record %0d in the data file", records);
					$display("Simulation failed");
					$fatal(1);
				end
			end
		end
		$fclose(fd);

		// every root, low and high command mix with en high, one beat each
		for (int c = 0; c < CMD_MIXES; c++)
		begin
			wb_write(name_t'("sweep_cfg"), REG_CFG, {25'b0, 6'(c), 1'b1});
			send_stream(name_t'("sweep_beat"), 1);
		end

		// random configs with the tree disabled in the last round
		for (int r = 0; r < ROUNDS; r++)
		begin
			word  = next_rand();
			cfg_w = {word[31:1], 1'(r != ROUNDS - 1)};
			wb_write(name_t'("rand_cfg"), REG_CFG, cfg_w);
			wb_read(name_t'("rand_cfg_rb"), REG_CFG, rd);
			check_eq(name_t'("rand_cfg_rb"), "cfg readback", cmp_t'(cfg_w[6:0]),
				cmp_t'(rd));
			send_stream(name_t'("rand_stream"), STREAM_LEN);
			for (int k = 0; k < NUM_LEAVES; k++)
				read_check(name_t'("rand_cnt"), wb_addr_t'(k + 1),
					model_reg(wb_addr_t'(k + 1)));
		end

		// counters are read only
		wb_write(name_t'("rand_cnt_wr"), REG_CNT2, next_rand());
		read_check(name_t'("rand_cnt_wr_rb"), REG_CNT2, model_reg(REG_CNT2));

		$display("Simulation passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: bench/dist_testdata.txt
# W name addr data | R name addr expected | all values hex
# B name word leaf_valid leaf0 leaf1 leaf2 leaf3
R rst_cfg 0 00000000
R rst_cnt0 1 00000000
R rst_cnt1 2 00000000
R rst_cnt2 3 00000000
R rst_cnt3 4 00000000
W dis_cfg 0 0000007e
B dis_beat 11111111 0 00000000 00000000 00000000 00000000
W none_cfg 0 00000079
B none_beat 22222222 0 00000000 00000000 00000000 00000000
R none_cnt0 1 00000000
R none_cnt3 4 00000000
W dup_cfg 0 0000007f
B dup_beat a5a5a5a5 f a5a5a5a5 a5a5a5a5 a5a5a5a5 a5a5a5a5
W ll_cfg 0 0000006b
B ll_beat 0000c0de 1 0000c0de 00000000 00000000 00000000
W lh_cfg 0 00000073
B lh_beat 13579bdf 2 00000000 13579bdf 00000000 00000000
W hl_cfg 0 0000003d
B hl_beat 2468ace0 4 00000000 00000000 2468ace0 00000000
W hh_cfg 0 0000005d
B hh_beat fedcba98 8 00000000 00000000 00000000 fedcba98
W split_cfg 0 00000037
B split_beat 0badf00d 6 00000000 0badf00d 0badf00d 00000000
W lowdup_cfg 0 0000007b
B lowdup_beat 5a5a5a5a 3 5a5a5a5a 5a5a5a5a 00000000 00000000
W cnt_wr 1 deadbeef
W bad_wr 6 12345678
R cnt0_sum 1 00000003
R cnt1_sum 2 00000004
R cnt2_sum 3 00000003
R cnt3_sum 4 00000002
R cfg_rb 0 0000007b
R unmapped 5 00000000

// File: all.f
design/dist_pkg.sv
design/mux_2x1_comb.sv
design/distribute_1x2_comb.sv
design/dist_tree.sv
design/dist_cfg_wb.sv
design/dist_tree_top.sv
bench/tb_dist_tree.sv

// File: Makefile
# Verilator build and run for the stream distribution tree
# override any variable on the command line, e.g. make run BUILD_DIR=build

VERILATOR ?= verilator
TOP       ?= tb_dist_tree
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert
EXTRA     ?=

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) $(EXTRA) -j $(JOBS) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -f $(FILELIST)

# exit status of the simulator is the test result
run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(BUILD_DIR)
